/* testbench/muldiv_trace.txt */
// columns: opcode  A  B  done  acc  b  ov   (all hex, one operation per line)
// done 01 = a done pulse is expected, 00 = start must be ignored, FF = end of trace

// MUL AB, A = 0, B = 0 and FFh x FFh included
A4 0C 0D 01 9C 00 00
A4 00 37 01 00 00 00
A4 5A 00 01 00 00 00
A4 FF FF 01 01 FE 01
A4 10 10 01 00 01 01
A4 01 FF 01 FF 00 00
A4 0F 11 01 FF 00 00
A4 80 02 01 00 01 01
A4 03 55 01 FF 00 00
A4 20 07 01 E0 00 00
A4 C8 64 01 20 4E 01

// DIV AB
84 64 07 01 0E 02 00
84 FF 01 01 FF 00 00
84 05 09 01 00 05 00
84 FF FF 01 01 00 00
84 80 03 01 2A 02 00
84 00 05 01 00 00 00
84 C8 0A 01 14 00 00
84 EF 10 01 0E 0F 00
84 01 80 01 00 01 00

// DIV AB by zero
84 2A 00 01 FF 2A 01
84 00 00 01 FF 00 01
84 FF 00 01 FF FF 01

// unsupported opcodes, last result must stay
00 12 34 00 FF FF 01
A5 03 04 00 FF FF 01
A4 07 06 01 2A 00 00
C4 01 01 00 2A 00 00

// a few more mixed
84 E1 0F 01 0F 00 00
A4 FE 81 01 FE 7F 01
84 7B 0C 01 0A 03 00

// end marker
00 00 00 FF 00 00 00

/* vlog.f */
common/muldiv_types_pkg.sv
common/muldiv_op_pkg.sv
source/mul_unit.sv
source/div_unit.sv
source/muldiv_sequencer.sv
source/muldiv_top.sv
testbench/tb_muldiv.sv

/* Makefile */
# Verilator build and run of the MUL/DIV unit testbench

SOURCES := $(shell grep -v '^+' vlog.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_muldiv: vlog.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_muldiv -f vlog.f

# the trace is read at run time from the project root
run: obj_dir/Vtb_muldiv testbench/muldiv_trace.txt
	@out="$$(./obj_dir/Vtb_muldiv)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

/* testbench/tb_muldiv.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_muldiv;

   import muldiv_types_pkg::*;
   import muldiv_op_pkg::*;

   localparam int TRACE_MAX = 64;    // lines
   localparam int FIELDS    = 7;     // bytes per trace line
   localparam int DONE_WAIT = 400;
   localparam int IDLE_WAIT = 50;
   localparam int RAND_OPS  = 40;

   logic  i_clk;
   logic  i_nrst;
   logic  i_start;
   op_t   i_op;
   byte_t i_a;
   byte_t i_b;
   byte_t o_acc;
   byte_t o_b;
   logic  o_ov;
   logic  o_busy;
   logic  o_done;

   logic [7:0]  trace_mem [0:TRACE_MAX*FIELDS-1];
   logic [31:0] lcg_state;
   int          n_checks;
   int          n_errors;
   int          n_timeouts;

   muldiv_top DUT (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_start (i_start),
      .i_op    (i_op),
      .i_a     (i_a),
      .i_b     (i_b),
      .o_acc   (o_acc),
      .o_b     (o_b),
      .o_ov    (o_ov),
      .o_busy  (o_busy),
      .o_done  (o_done)
   );

   initial i_clk = 1'b0;
   always #50 i_clk = ~i_clk;   // 100 ns period

   ////////////////////////////////////////
   // reference model and random source

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic void model_op(input op_t op, input byte_t a, input byte_t b,
                                    output byte_t acc, output byte_t rb, output logic ov);
      word_t prod;
      prod = word_t'(a) * word_t'(b);
      if (op == OP_MUL) begin
         acc = prod[BYTE_W-1:0];
         rb  = prod[2*BYTE_W-1:BYTE_W];
         ov  = (prod[2*BYTE_W-1:BYTE_W] != 8'h00);
      end else if (b == 8'h00) begin
         acc = 8'hFF;    // 8051 leaves these undefined, this unit gives FFh and A
         rb  = a;
         ov  = 1'b1;
      end else begin
         acc = a / b;
         rb  = a % b;
         ov  = 1'b0;
      end
   endfunction

   ////////////////////////////////////////
   // drive and wait

   task automatic pulse_start(input op_t op, input byte_t a, input byte_t b);
      @(negedge i_clk);
      i_op    = op;
      i_a     = a;
      i_b     = b;
      i_start = 1'b1;
      @(negedge i_clk);
      i_start = 1'b0;
   endtask

   task automatic wait_done(output logic seen);
      int cycles;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < DONE_WAIT) begin
         @(negedge i_clk);
         cycles++;
         if (o_done) seen = 1'b1;
      end
      if (!seen) begin
         n_timeouts++;
         $display("timeout: no done pulse within %0d cycles, time %0t", DONE_WAIT, $time);
      end
   endtask

   // nothing may happen for a while
   task automatic watch_idle();
      int cycles;
      for (cycles = 0; cycles < IDLE_WAIT; cycles++) begin
         @(negedge i_clk);
         if (o_done || o_busy) begin
            n_errors++;
            $display("error at %0t: unit reacted to an ignored start", $time);
         end
      end
   endtask

   task automatic check_outputs(input op_t op, input byte_t a, input byte_t b,
                                input byte_t exp_acc, input byte_t exp_b, input logic exp_ov);
      n_checks++;
      if (o_acc !== exp_acc || o_b !== exp_b || o_ov !== exp_ov) begin
         n_errors++;
         $display("error at %0t: op %h a %h b %h gave acc %h b %h ov %b, expected %h %h %b",
                  $time, op, a, b, o_acc, o_b, o_ov, exp_acc, exp_b, exp_ov);
      end
   endtask

   task automatic run_op(input op_t op, input byte_t a, input byte_t b, input logic exp_done,
                         input byte_t exp_acc, input byte_t exp_b, input logic exp_ov);
      logic seen;
      pulse_start(op, a, b);
      if (exp_done) begin
         wait_done(seen);
         if (seen) begin
            n_checks++;
            if (o_busy !== 1'b0) begin
               n_errors++;
               $display("error at %0t: busy still high with done", $time);
            end
            check_outputs(op, a, b, exp_acc, exp_b, exp_ov);
         end
      end else begin
         watch_idle();
         check_outputs(op, a, b, exp_acc, exp_b, exp_ov);   // old result kept
      end
   endtask

   ////////////////////////////////////////
   // main sequence

   initial begin
      int    idx;
      int    base;
      logic  at_end;
      logic  seen;
      op_t   r_op;
      byte_t r_a;
      byte_t r_b;
      byte_t e_acc;
      byte_t e_b;
      logic  e_ov;

      i_nrst     = 1'b0;
      i_start    = 1'b0;
      i_op       = 8'h00;
      i_a        = 8'h00;
      i_b        = 8'h00;
      n_checks   = 0;
      n_errors   = 0;
      n_timeouts = 0;
      lcg_state  = 32'd41701;
      $readmemh("testbench/muldiv_trace.txt", trace_mem);

      repeat (10) @(negedge i_clk);
      i_nrst = 1'b1;
      @(negedge i_clk);
      n_checks++;
      if (o_busy !== 1'b0 || o_done !== 1'b0) begin
         n_errors++;
         $display("error at %0t: busy or done high after reset", $time);
      end
      check_outputs(8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0);

      // trace replay up to the end marker
      idx    = 0;
      at_end = 1'b0;
      if ($isunknown(trace_mem[3])) begin
         n_errors++;
         $display("the trace file could not be read");
         at_end = 1'b1;
      end
      while (!at_end && idx < TRACE_MAX) begin
         base = idx * FIELDS;
         if (trace_mem[base+3] == 8'hFF) begin
            at_end = 1'b1;
         end else begin
            run_op(trace_mem[base], trace_mem[base+1], trace_mem[base+2],
                   trace_mem[base+3] != 8'h00, trace_mem[base+4], trace_mem[base+5],
                   trace_mem[base+6][0]);
            idx++;
         end
      end
      if (!at_end) begin
         n_errors++;
         $display("the trace file has no end marker");
      end

      // second start while busy must be dropped
      model_op(OP_MUL, 8'hFF, 8'h03, e_acc, e_b, e_ov);
      pulse_start(OP_MUL, 8'hFF, 8'h03);
      n_checks++;
      if (o_busy !== 1'b1) begin
         n_errors++;
         $display("error at %0t: busy not raised by an accepted start", $time);
      end
      repeat (3) @(negedge i_clk);
      pulse_start(OP_DIV, 8'h10, 8'h03);
      wait_done(seen);
      if (seen) begin
         check_outputs(OP_MUL, 8'hFF, 8'h03, e_acc, e_b, e_ov);
         watch_idle();
         check_outputs(OP_MUL, 8'hFF, 8'h03, e_acc, e_b, e_ov);
      end

      // random operations
      for (int n = 0; n < RAND_OPS; n++) begin
         lcg_state = lcg_next(lcg_state);
         r_op = lcg_state[15] ? OP_DIV : OP_MUL;
         r_a  = lcg_state[31:24];
         r_b  = lcg_state[23:16];
         if (r_op == OP_DIV && lcg_state[14:12] == 3'd0) r_b = 8'h00;   // some div by zero
         model_op(r_op, r_a, r_b, e_acc, e_b, e_ov);
         run_op(r_op, r_a, r_b, 1'b1, e_acc, e_b, e_ov);
      end

      $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
      if (n_errors == 0 && n_timeouts == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* source/muldiv_top.sv */
`timescale 1ns/1ps
`default_nettype none

// stand-alone MUL AB / DIV AB unit

module muldiv_top (
   input  logic                    i_clk,
   input  logic                    i_nrst,
   input  logic                    i_start,
   input  muldiv_op_pkg::op_t      i_op,
   input  muldiv_types_pkg::byte_t i_a,
   input  muldiv_types_pkg::byte_t i_b,
   output muldiv_types_pkg::byte_t o_acc,
   output muldiv_types_pkg::byte_t o_b,
   output logic                    o_ov,
   output logic                    o_busy,
   output logic                    o_done
);

   import muldiv_types_pkg::*;

   ////////////////////////////////////////
   // sequencer to engines

   logic  mul_start;
   logic  div_start;
   byte_t opa;
   byte_t opb;
   word_t product;
   logic  mul_done;
   byte_t quotient;
   byte_t remainder;
   logic  div_done;

   muldiv_sequencer u_seq (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_start     (i_start),
      .i_op        (i_op),
      .i_a         (i_a),
      .i_b         (i_b),
      .i_product   (product),
      .i_mul_done  (mul_done),
      .i_quotient  (quotient),
      .i_remainder (remainder),
      .i_div_done  (div_done),
      .o_mul_start (mul_start),
      .o_div_start (div_start),
      .o_opa       (opa),
      .o_opb       (opb),
      .o_acc       (o_acc),
      .o_b         (o_b),
      .o_ov        (o_ov),
      .o_busy      (o_busy),
      .o_done      (o_done)
   );

   ////////////////////////////////////////
   // engines, side by side

   mul_unit u_mul (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_start   (mul_start),
      .i_opa     (opa),
      .i_opb     (opb),
      .o_product (product),
      .o_done    (mul_done)
   );

   div_unit u_div (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_start     (div_start),
      .i_opa       (opa),
      .i_opb       (opb),
      .o_quotient  (quotient),
      .o_remainder (remainder),
      .o_done      (div_done)
   );

endmodule

`default_nettype wire

/* source/muldiv_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// accepts MUL AB / DIV AB, runs one engine, registers A, B and OV

module muldiv_sequencer (
   input  logic                    i_clk,
   input  logic                    i_nrst,
   input  logic                    i_start,
   input  muldiv_op_pkg::op_t      i_op,
   input  muldiv_types_pkg::byte_t i_a,
   input  muldiv_types_pkg::byte_t i_b,
   input  muldiv_types_pkg::word_t i_product,
   input  logic                    i_mul_done,
   input  muldiv_types_pkg::byte_t i_quotient,
   input  muldiv_types_pkg::byte_t i_remainder,
   input  logic                    i_div_done,
   output logic                    o_mul_start,
   output logic                    o_div_start,
   output muldiv_types_pkg::byte_t o_opa,
   output muldiv_types_pkg::byte_t o_opb,
   output muldiv_types_pkg::byte_t o_acc,
   output muldiv_types_pkg::byte_t o_b,
   output logic                    o_ov,
   output logic                    o_busy,
   output logic                    o_done
);

   import muldiv_types_pkg::*;
   import muldiv_op_pkg::*;

   ////////////////////////////////////////
   // decode

   logic  is_mul;
   logic  is_div;
   logic  accept;
   logic  use_div;      // engine picked at accept
   logic  eng_done;
   logic  finish;
   byte_t res_acc;
   byte_t res_b;
   logic  res_ov;

   assign is_mul = (i_op == OP_MUL);
   assign is_div = (i_op == OP_DIV);

   // unknown opcodes and starts while busy fall through here
   assign accept = i_start & ~o_busy & (is_mul | is_div);

   assign eng_done = use_div ? i_div_done : i_mul_done;
   assign finish   = o_busy & eng_done;

   ////////////////////////////////////////
   // result select

   always_comb begin
      if (use_div) begin
         res_acc = i_quotient;
         res_b   = i_remainder;
         res_ov  = (o_opb == '0);                    // divide by zero
      end else begin
         res_acc = i_product[BYTE_W-1:0];
         res_b   = i_product[2*BYTE_W-1:BYTE_W];
         res_ov  = (i_product[2*BYTE_W-1:BYTE_W] != '0);   // product above FFh
      end
   end

   ////////////////////////////////////////
   // control

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_busy      <= 1'b0;
         o_done      <= 1'b0;
         o_mul_start <= 1'b0;
         o_div_start <= 1'b0;
         use_div     <= 1'b0;
      end else begin
         o_mul_start <= accept & is_mul;     // one cycle pulses
         o_div_start <= accept & is_div;
         o_done      <= finish;
         if (accept) begin
            o_busy  <= 1'b1;
            use_div <= is_div;
         end else if (finish) begin
            o_busy <= 1'b0;
         end
      end
   end

   // operands stay put until the engine answers
   always_ff @(posedge i_clk) begin
      if (accept) begin
         o_opa <= i_a;
         o_opb <= i_b;
      end
   end

   ////////////////////////////////////////
   // output registers

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_acc <= '0;
         o_b   <= '0;
         o_ov  <= 1'b0;
      end else if (finish) begin
         o_acc <= res_acc;
         o_b   <= res_b;
         o_ov  <= res_ov;
      end
   end

endmodule

`default_nettype wire

/* source/div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// restoring divider, one quotient bit per cycle, msb first

module div_unit (
   input  logic                    i_clk,
   input  logic                    i_nrst,
   input  logic                    i_start,
   input  muldiv_types_pkg::byte_t i_opa,
   input  muldiv_types_pkg::byte_t i_opb,
   output muldiv_types_pkg::byte_t o_quotient,
   output muldiv_types_pkg::byte_t o_remainder,
   output logic                    o_done
);

   import muldiv_types_pkg::*;

   ////////////////////////////////////////
   // signals

   byte_t           dividend;   // shifts left, msb feeds the remainder
   byte_t           divisor;    // own copy for the whole run
   byte_t           quotient;
   logic [BYTE_W:0] part_rem;
   logic [BYTE_W:0] shifted;
   logic [BYTE_W:0] wide_div;
   logic            fits;
   step_cnt_t       step_cnt;
   logic            run;

   assign shifted  = {part_rem[BYTE_W-1:0], dividend[BYTE_W-1]};
   assign wide_div = {1'b0, divisor};

   // zero divisor always fits, giving FFh and the dividend back
   assign fits = (shifted >= wide_div);

   ////////////////////////////////////////
   // step counter

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         run      <= 1'b0;
         step_cnt <= '0;
         o_done   <= 1'b0;
      end else begin
         o_done <= 1'b0;
         if (i_start) begin
            run      <= 1'b1;
            step_cnt <= step_cnt_t'(DIV_STEPS - 1);
         end else if (run) begin
            if (step_cnt == '0) begin
               run    <= 1'b0;
               o_done <= 1'b1;    // last step and done on one edge
            end else begin
               step_cnt <= step_cnt - 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////
   // datapath

   always_ff @(posedge i_clk) begin
      if (i_start) begin
         dividend <= i_opa;
         divisor  <= i_opb;
         part_rem <= '0;
         quotient <= '0;
      end else if (run) begin
         part_rem <= fits ? (shifted - wide_div) : shifted;
         quotient <= {quotient[BYTE_W-2:0], fits};
         dividend <= {dividend[BYTE_W-2:0], 1'b0};
      end
   end

   assign o_quotient  = quotient;
   assign o_remainder = part_rem[BYTE_W-1:0];   // top bit is spent after restore

endmodule

`default_nettype wire

/* source/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// multiplies by adding B once per cycle for A cycles

module mul_unit (
   input  logic                    i_clk,
   input  logic                    i_nrst,
   input  logic                    i_start,
   input  muldiv_types_pkg::byte_t i_opa,
   input  muldiv_types_pkg::byte_t i_opb,
   output muldiv_types_pkg::word_t o_product,
   output logic                    o_done
);

   import muldiv_types_pkg::*;

   ////////////////////////////////////////
   // signals

   byte_t count;        // additions still to do
   logic  add_en;
   logic  last_add;
   word_t product;
   word_t addend;

   assign add_en   = (count != '0);
   assign last_add = add_en & (count == byte_t'(1));
   assign addend   = {{BYTE_W{1'b0}}, i_opb};   // B held by the sequencer

   ////////////////////////////////////////
   // control

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         count  <= '0;
         o_done <= 1'b0;
      end else begin
         o_done <= 1'b0;
         if (i_start) begin
            count  <= i_opa;
            o_done <= (i_opa == '0);      // A of zero finishes at once
         end else if (add_en) begin
            count <= count - 1'b1;
            if (last_add) begin
               o_done <= 1'b1;            // final add lands with done
            end
         end
      end
   end

   ////////////////////////////////////////
   // accumulator

   always_ff @(posedge i_clk) begin
      if (i_start) begin
         product <= '0;
      end else if (add_en) begin
         product <= product + addend;
      end
   end

   // held until the next start
   assign o_product = product;

endmodule

`default_nettype wire

/* common/muldiv_op_pkg.sv */
`default_nettype none

package muldiv_op_pkg;

   // raw 8051 opcode byte
   typedef logic [7:0] op_t;

   ////////////////////////////////////////
   // supported opcodes

   localparam op_t OP_MUL = 8'hA4;   // mul ab
   localparam op_t OP_DIV = 8'h84;   // div ab

endpackage

`default_nettype wire

/* common/muldiv_types_pkg.sv */
`default_nettype none

package muldiv_types_pkg;

   ////////////////////////////////////////
   // operand and result widths

   localparam int BYTE_W = 8;               // one 8051 register

   typedef logic [BYTE_W-1:0]   byte_t;     // A, B, quotient, remainder
   typedef logic [2*BYTE_W-1:0] word_t;     // full MUL AB product

   ////////////////////////////////////////
   // divider iteration

   // one step per dividend bit
   localparam int DIV_STEPS = BYTE_W;

   typedef logic [$clog2(DIV_STEPS)-1:0] step_cnt_t;

endpackage

`default_nettype wire
